//--- hw/kv_pkg.sv
package kv_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // sizes and wire constants
   ////////////////////////////////////////////////////////////////////////////

   localparam int WORD_W      = 64;
   localparam int KEY_W       = 16;
   localparam int OPAQUE_W    = 32;
   localparam int INDEX_W     = 4;
   localparam int TABLE_DEPTH = 16;

   localparam logic [7:0] REQ_MAGIC  = 8'h80;
   localparam logic [7:0] RESP_MAGIC = 8'h81;

   typedef enum logic [7:0] {
      OP_GET    = 8'h00,
      OP_SET    = 8'h01,
      OP_DELETE = 8'h04
   } kv_op_e;

   typedef enum logic [7:0] {
      ST_OK        = 8'h00,
      ST_NOT_FOUND = 8'h01
   } kv_status_e;

   ////////////////////////////////////////////////////////////////////////////
   // header word, read as request or written as response
   ////////////////////////////////////////////////////////////////////////////

   // opcode kept raw here, a request may carry an unknown one
   typedef struct packed {
      logic [7:0]          magic;
      logic [7:0]          opcode;
      logic [KEY_W-1:0]    key;
      logic [OPAQUE_W-1:0] opaque;
   } kv_req_hdr_t;

   typedef struct packed {
      logic [7:0]          magic;
      logic [7:0]          opcode;
      logic [7:0]          status;
      logic [7:0]          reserved;
      logic [OPAQUE_W-1:0] opaque;
   } kv_resp_hdr_t;

   typedef union packed {
      kv_req_hdr_t  req;
      kv_resp_hdr_t resp;
   } kv_hdr_u;

   ////////////////////////////////////////////////////////////////////////////
   // stream word and records between the blocks
   ////////////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic [WORD_W-1:0] data;
      logic              last;
   } kv_beat_t;

   typedef struct packed {
      kv_op_e              op;
      logic [KEY_W-1:0]    key;
      logic [OPAQUE_W-1:0] opaque;
      logic [WORD_W-1:0]   value;
   } kv_req_t;

   typedef struct packed {
      kv_op_e              op;
      kv_status_e          status;
      logic [OPAQUE_W-1:0] opaque;
      logic [WORD_W-1:0]   value;
      logic                has_value;
   } kv_resp_t;

   typedef struct packed {
      logic              valid;
      logic [KEY_W-1:0]  key;
      logic [WORD_W-1:0] value;
   } kv_entry_t;

endpackage

//--- hw/request_parser.sv
`timescale 1ns/1ns

module request_parser (
   input  logic             axi_clk,
   input  logic             arst_n,
   input  kv_pkg::kv_beat_t in_beat,
   input  logic             in_valid,
   output logic             in_ready,
   output kv_pkg::kv_req_t  req,
   output logic             req_valid,
   input  logic             req_ready
);
   import kv_pkg::*;

   // position in the incoming packet, START only right after reset
   typedef enum logic [1:0] {
      PS_START,
      PS_HEADER,
      PS_VALUE,
      PS_DISCARD
   } parse_state_e;

   parse_state_e state;
   kv_hdr_u      hdr;
   logic         hdr_ok;
   logic         word_take;
   logic         req_done;

   assign hdr       = in_beat.data;
   assign in_ready  = (state != PS_START) && (!req_valid || req_ready);
   assign word_take = in_valid && in_ready;

   // magic and opcode check on the first word
   always_comb begin
      hdr_ok = 1'b0;
      if (hdr.req.magic == REQ_MAGIC) begin
         case (hdr.req.opcode)
            OP_GET, OP_SET, OP_DELETE: hdr_ok = 1'b1;
            default:                   hdr_ok = 1'b0;
         endcase
      end
   end

   // word count per opcode: SET ends on its second word, the rest on the first
   always_comb begin
      req_done = 1'b0;
      if (word_take && in_beat.last) begin
         case (state)
            PS_HEADER: req_done = hdr_ok && (hdr.req.opcode != OP_SET);
            PS_VALUE:  req_done = 1'b1;
            default:   req_done = 1'b0;
         endcase
      end
   end

   always_ff @(posedge axi_clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= PS_START;
         req_valid <= 1'b0;
      end else begin
         if (req_done) begin
            req_valid <= 1'b1;
         end else if (req_ready) begin
            req_valid <= 1'b0;
         end

         case (state)
            PS_START: state <= PS_HEADER;
            PS_HEADER: begin
               // a single-word SET falls through here and is dropped
               if (word_take && !in_beat.last) begin
                  if (hdr_ok && hdr.req.opcode == OP_SET) begin
                     state <= PS_VALUE;
                  end else begin
                     state <= PS_DISCARD;
                  end
               end
            end
            PS_VALUE: begin
               if (word_take) begin
                  state <= in_beat.last ? PS_HEADER : PS_DISCARD;
               end
            end
            default: begin
               if (word_take && in_beat.last) begin
                  state <= PS_HEADER;
               end
            end
         endcase
      end
   end

   // request fields, only written while nothing is held back
   always_ff @(posedge axi_clk) begin
      if (word_take && state == PS_HEADER) begin
         req.op     <= kv_op_e'(hdr.req.opcode);
         req.key    <= hdr.req.key;
         req.opaque <= hdr.req.opaque;
         req.value  <= '0;
      end
      if (word_take && state == PS_VALUE) begin
         req.value <= in_beat.data;
      end
   end

endmodule

//--- hw/kv_control.sv
`timescale 1ns/1ns

module kv_control (
   input  logic                     axi_clk,
   input  logic                     arst_n,
   input  kv_pkg::kv_req_t          req,
   input  logic                     req_valid,
   output logic                     req_ready,
   output logic                     lookup_en,
   output logic [kv_pkg::KEY_W-1:0] lookup_key,
   input  kv_pkg::kv_entry_t        lookup_entry,
   output logic                     store_en,
   output logic [kv_pkg::KEY_W-1:0] store_key,
   output kv_pkg::kv_entry_t        store_entry,
   output kv_pkg::kv_resp_t         resp,
   output logic                     resp_valid,
   input  logic                     resp_ready
);
   import kv_pkg::*;

   typedef enum logic [1:0] {
      CS_IDLE,
      CS_LOOKUP,
      CS_RESPOND
   } ctrl_state_e;

   ctrl_state_e state;
   kv_req_t     cur;
   logic        hit;

   ////////////////////////////////////////////////////////////////////////////
   // accept and lookup
   ////////////////////////////////////////////////////////////////////////////

   // one request in flight, so only take a new one when idle
   assign req_ready  = (state == CS_IDLE);
   assign lookup_en  = req_valid && req_ready;
   assign lookup_key = req.key;

   // table data is back during CS_LOOKUP
   assign hit        = lookup_entry.valid && (lookup_entry.key == cur.key);
   assign resp_valid = (state == CS_RESPOND);

   always_ff @(posedge axi_clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= CS_IDLE;
      end else begin
         case (state)
            CS_IDLE: begin
               if (lookup_en) begin
                  state <= CS_LOOKUP;
               end
            end
            CS_LOOKUP: state <= CS_RESPOND;
            default: begin
               if (resp_ready) begin
                  state <= CS_IDLE;
               end
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // table update
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      store_en          = 1'b0;
      store_key         = cur.key;
      store_entry.valid = 1'b0;
      store_entry.key   = cur.key;
      store_entry.value = '0;
      if (state == CS_LOOKUP) begin
         case (cur.op)
            OP_SET: begin
               // collision just overwrites the slot
               store_en          = 1'b1;
               store_entry.valid = 1'b1;
               store_entry.value = cur.value;
            end
            OP_DELETE: store_en = hit;
            default:   store_en = 1'b0;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // response record
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge axi_clk) begin
      if (lookup_en) begin
         cur <= req;
      end
      if (state == CS_LOOKUP) begin
         resp.op        <= cur.op;
         resp.opaque    <= cur.opaque;
         resp.value     <= hit ? lookup_entry.value : '0;
         resp.has_value <= (cur.op == OP_GET) && hit;
         case (cur.op)
            OP_GET, OP_DELETE: resp.status <= hit ? ST_OK : ST_NOT_FOUND;
            default:           resp.status <= ST_OK;
         endcase
      end
   end

endmodule

//--- hw/hash_table.sv
`timescale 1ns/1ns

module hash_table (
   input  logic                     axi_clk,
   input  logic                     arst_n,
   input  logic                     lookup_en,
   input  logic [kv_pkg::KEY_W-1:0] lookup_key,
   output kv_pkg::kv_entry_t        lookup_entry,
   input  logic                     store_en,
   input  logic [kv_pkg::KEY_W-1:0] store_key,
   input  kv_pkg::kv_entry_t        store_entry
);
   import kv_pkg::*;

   // xor of the four key nibbles
   function automatic logic [INDEX_W-1:0] hash_index(input logic [KEY_W-1:0] key);
      return key[15:12] ^ key[11:8] ^ key[7:4] ^ key[3:0];
   endfunction

   logic [KEY_W-1:0]       key_mem [TABLE_DEPTH];
   logic [WORD_W-1:0]      value_mem [TABLE_DEPTH];
   logic [TABLE_DEPTH-1:0] valid_q;
   logic [INDEX_W-1:0]     rd_idx;
   logic [INDEX_W-1:0]     wr_idx;

   assign rd_idx = hash_index(lookup_key);
   assign wr_idx = hash_index(store_key);

   // valid bits are the only state cleared by reset
   always_ff @(posedge axi_clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= '0;
      end else if (store_en) begin
         valid_q[wr_idx] <= store_entry.valid;
      end
   end

   always_ff @(posedge axi_clk) begin
      if (store_en) begin
         key_mem[wr_idx]   <= store_entry.key;
         value_mem[wr_idx] <= store_entry.value;
      end
   end

   // registered read, data one cycle after lookup_en
   always_ff @(posedge axi_clk) begin
      if (lookup_en) begin
         lookup_entry.valid <= valid_q[rd_idx];
         lookup_entry.key   <= key_mem[rd_idx];
         lookup_entry.value <= value_mem[rd_idx];
      end
   end

endmodule

//--- hw/response_composer.sv
`timescale 1ns/1ns

module response_composer (
   input  logic             axi_clk,
   input  logic             arst_n,
   input  kv_pkg::kv_resp_t resp,
   input  logic             resp_valid,
   output logic             resp_ready,
   output kv_pkg::kv_beat_t out_beat,
   output logic             out_valid,
   input  logic             out_ready
);
   import kv_pkg::*;

   kv_hdr_u           hdr;
   logic              value_pending;
   logic [WORD_W-1:0] value_q;
   logic              resp_take;
   logic              out_take;

   // no new record until both words have gone out
   assign resp_ready = !out_valid;
   assign resp_take  = resp_valid && resp_ready;
   assign out_take   = out_valid && out_ready;

   // response view of the header word
   always_comb begin
      hdr.resp.magic    = RESP_MAGIC;
      hdr.resp.opcode   = resp.op;
      hdr.resp.status   = resp.status;
      hdr.resp.reserved = 8'h00;
      hdr.resp.opaque   = resp.opaque;
   end

   ////////////////////////////////////////////////////////////////////////////
   // output word sequencing
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge axi_clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid     <= 1'b0;
         value_pending <= 1'b0;
      end else if (resp_take) begin
         out_valid     <= 1'b1;
         value_pending <= resp.has_value;
      end else if (out_take) begin
         // header gone, value word follows straight after
         if (value_pending) begin
            value_pending <= 1'b0;
         end else begin
            out_valid <= 1'b0;
         end
      end
   end

   // word held as is until out_ready
   always_ff @(posedge axi_clk) begin
      if (resp_take) begin
         out_beat.data <= hdr;
         out_beat.last <= !resp.has_value;
         value_q       <= resp.value;
      end else if (out_take && value_pending) begin
         out_beat.data <= value_q;
         out_beat.last <= 1'b1;
      end
   end

endmodule

//--- hw/kv_top.sv
`timescale 1ns/1ns

module kv_top (
   input  logic             axi_clk,
   input  logic             arst_n,
   input  kv_pkg::kv_beat_t in_beat,
   input  logic             in_valid,
   output logic             in_ready,
   output kv_pkg::kv_beat_t out_beat,
   output logic             out_valid,
   input  logic             out_ready
);
   import kv_pkg::*;

   // parser to control
   kv_req_t           req;
   logic              req_valid;
   logic              req_ready;

   // control to composer
   kv_resp_t          resp;
   logic              resp_valid;
   logic              resp_ready;

   // table access, no handshake
   logic              lookup_en;
   logic [KEY_W-1:0]  lookup_key;
   kv_entry_t         lookup_entry;
   logic              store_en;
   logic [KEY_W-1:0]  store_key;
   kv_entry_t         store_entry;

   request_parser u_request_parser (
      .axi_clk   (axi_clk),
      .arst_n    (arst_n),
      .in_beat   (in_beat),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .req       (req),
      .req_valid (req_valid),
      .req_ready (req_ready)
   );

   kv_control u_kv_control (
      .axi_clk      (axi_clk),
      .arst_n       (arst_n),
      .req          (req),
      .req_valid    (req_valid),
      .req_ready    (req_ready),
      .lookup_en    (lookup_en),
      .lookup_key   (lookup_key),
      .lookup_entry (lookup_entry),
      .store_en     (store_en),
      .store_key    (store_key),
      .store_entry  (store_entry),
      .resp         (resp),
      .resp_valid   (resp_valid),
      .resp_ready   (resp_ready)
   );

   hash_table u_hash_table (
      .axi_clk      (axi_clk),
      .arst_n       (arst_n),
      .lookup_en    (lookup_en),
      .lookup_key   (lookup_key),
      .lookup_entry (lookup_entry),
      .store_en     (store_en),
      .store_key    (store_key),
      .store_entry  (store_entry)
   );

   response_composer u_response_composer (
      .axi_clk    (axi_clk),
      .arst_n     (arst_n),
      .resp       (resp),
      .resp_valid (resp_valid),
      .resp_ready (resp_ready),
      .out_beat   (out_beat),
      .out_valid  (out_valid),
      .out_ready  (out_ready)
   );

endmodule

//--- verification/kv_props.sv
`timescale 1ns/1ns

module kv_props (
   input logic             axi_clk,
   input logic             arst_n,
   input logic             in_ready,
   input kv_pkg::kv_beat_t out_beat,
   input logic             out_valid,
   input logic             out_ready
);

   // words of the current response already gone out
   logic [1:0] words_sent;

   // number of failed assertions so far
   int fail_count = 0;

   always_ff @(posedge axi_clk or negedge arst_n) begin
      if (!arst_n) begin
         words_sent <= '0;
      end else if (out_valid && out_ready) begin
         if (out_beat.last) begin
            words_sent <= '0;
         end else if (words_sent != 2'd3) begin
            words_sent <= words_sent + 2'd1;
         end
      end
   end

   held_under_stall: assert property (@(posedge axi_clk) disable iff (!arst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_beat))
      else begin
         $error("output word changed while stalled");
         fail_count++;
      end

   quiet_in_reset: assert property (@(posedge axi_clk)
      !arst_n |-> !in_ready && !out_valid)
      else begin
         $error("in_ready or out_valid high during reset");
         fail_count++;
      end

   two_words_max: assert property (@(posedge axi_clk) disable iff (!arst_n)
      out_valid |-> words_sent < 2'd2)
      else begin
         $error("response longer than two words");
         fail_count++;
      end

endmodule

bind kv_top kv_props props (
   .axi_clk   (axi_clk),
   .arst_n    (arst_n),
   .in_ready  (in_ready),
   .out_beat  (out_beat),
   .out_valid (out_valid),
   .out_ready (out_ready)
);

//--- verification/tb_kv_top.sv
`timescale 1ns/1ns

module tb_kv_top;
   import kv_pkg::*;

   localparam int WAIT_LIMIT = 500;
   localparam int BURST_LEN  = 20;

   logic     axi_clk = 1'b0;
   logic     arst_n;
   kv_beat_t in_beat;
   logic     in_valid;
   logic     in_ready;
   kv_beat_t out_beat;
   logic     out_valid;
   logic     out_ready;
   integer   seed = 32'h40c8_72c0;

   // expected table contents, keyed by slot
   logic [KEY_W-1:0]  model_key [int];
   logic [WORD_W-1:0] model_val [int];

   kv_top dut (
      .axi_clk   (axi_clk),
      .arst_n    (arst_n),
      .in_beat   (in_beat),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_beat  (out_beat),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   always #4 axi_clk = ~axi_clk;

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         stop_on_error($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, exp));
      end
   endtask

   // any failed stream assertion ends the run
   always @(negedge axi_clk) begin
      if (dut.props.fail_count != 0) begin
         stop_on_error("a stream assertion in the bound checker failed");
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////////////////////

   // nibble xor of the key
   function automatic int slot_of(input logic [KEY_W-1:0] key);
      logic [3:0] acc;
      acc = 4'h0;
      for (int n = 0; n < 4; n++) begin
         acc = acc ^ key[n*4 +: 4];
      end
      return int'(acc);
   endfunction

   function automatic logic [63:0] req_word(input logic [7:0] magic, input logic [7:0] opcode,
                                            input logic [15:0] key, input logic [31:0] opaque);
      kv_hdr_u h;
      h.req.magic  = magic;
      h.req.opcode = opcode;
      h.req.key    = key;
      h.req.opaque = opaque;
      return h;
   endfunction

   task automatic predict(input kv_op_e op, input logic [15:0] key, input logic [63:0] value,
                          input logic [31:0] opaque, output kv_resp_t e);
      int slot;
      bit hit;
      slot = slot_of(key);
      hit  = model_key.exists(slot) && (model_key[slot] == key);
      e.op        = op;
      e.opaque    = opaque;
      e.status    = ST_OK;
      e.value     = '0;
      e.has_value = 1'b0;
      case (op)
         OP_GET: begin
            if (hit) begin
               e.value     = model_val[slot];
               e.has_value = 1'b1;
            end else begin
               e.status = ST_NOT_FOUND;
            end
         end
         // older entry in the slot is simply replaced
         OP_SET: begin
            model_key[slot] = key;
            model_val[slot] = value;
         end
         default: begin
            if (hit) begin
               model_key.delete(slot);
               model_val.delete(slot);
            end else begin
               e.status = ST_NOT_FOUND;
            end
         end
      endcase
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // stream drivers
   ////////////////////////////////////////////////////////////////////////////

   task automatic send_request(input logic [63:0] hdr, input logic [63:0] value,
                               input int words, input bit drop_valid);
      int waited;
      for (int i = 0; i < words; i++) begin
         @(negedge axi_clk);
         in_valid     = 1'b1;
         in_beat.data = (i == 0) ? hdr : value;
         in_beat.last = (i == words - 1);
         waited = 0;
         while (!in_ready) begin
            @(negedge axi_clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
               stop_on_error("timeout waiting for in_ready");
            end
         end
      end
      if (drop_valid) begin
         @(negedge axi_clk);
         in_valid = 1'b0;
      end
   endtask

   // word is taken on the rising edge after it is captured here
   task automatic get_word(output kv_beat_t b, input bit random_ready);
      int          waited;
      logic [31:0] rnd;
      waited = 0;
      do begin
         @(negedge axi_clk);
         rnd = $random(seed);
         out_ready = random_ready ? rnd[0] : 1'b1;
         waited++;
         if (waited > WAIT_LIMIT) begin
            stop_on_error("timeout waiting for out_valid");
         end
      end while (!(out_valid && out_ready));
      b = out_beat;
   endtask

   task automatic expect_response(input kv_resp_t e, input bit random_ready);
      kv_beat_t b;
      kv_hdr_u  h;
      get_word(b, random_ready);
      h = b.data;
      check_value("magic", h.resp.magic, RESP_MAGIC);
      check_value("opcode", h.resp.opcode, e.op);
      check_value("status", h.resp.status, e.status);
      check_value("reserved", h.resp.reserved, 8'h00);
      check_value("opaque", h.resp.opaque, e.opaque);
      check_value("header last", b.last, !e.has_value);
      if (e.has_value) begin
         get_word(b, random_ready);
         check_value("value", b.data, e.value);
         check_value("value last", b.last, 1'b1);
      end
      @(negedge axi_clk);
      out_ready = 1'b0;
   endtask

   task automatic expect_silence(input int cycles);
      for (int i = 0; i < cycles; i++) begin
         @(negedge axi_clk);
         if (out_valid) begin
            stop_on_error("a malformed request produced a response packet");
         end
      end
   endtask

   task automatic do_request(input kv_op_e op, input logic [15:0] key,
                             input logic [63:0] value, input logic [31:0] opaque);
      kv_resp_t e;
      predict(op, key, value, opaque, e);
      send_request(req_word(REQ_MAGIC, op, key, opaque), value, (op == OP_SET) ? 2 : 1, 1'b1);
      expect_response(e, 1'b0);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic test_get_empty();
      do_request(OP_GET, 16'h5a3c, 64'h0, 32'hcafe_0001);
   endtask

   task automatic test_set_get();
      logic [63:0] value;
      value = {$random(seed), $random(seed)};
      do_request(OP_SET, 16'h0777, value, 32'h0000_0021);
      do_request(OP_GET, 16'h0777, 64'h0, 32'h0000_0022);
   endtask

   task automatic test_delete();
      do_request(OP_SET, 16'h2481, 64'h0123_4567_89ab_cdef, 32'h0000_0031);
      // absent key in the occupied slot 15
      do_request(OP_DELETE, 16'h2591, 64'h0, 32'h0000_0034);
      do_request(OP_DELETE, 16'h2481, 64'h0, 32'h0000_0032);
      do_request(OP_GET, 16'h2481, 64'h0, 32'h0000_0033);
   endtask

   task automatic test_collision();
      // 1^2 and 3 both land in slot 3
      do_request(OP_SET, 16'h1200, 64'haaaa_0000_0000_1200, 32'h0000_0041);
      do_request(OP_SET, 16'h0030, 64'hbbbb_0000_0000_0030, 32'h0000_0042);
      do_request(OP_GET, 16'h1200, 64'h0, 32'h0000_0043);
      do_request(OP_GET, 16'h0030, 64'h0, 32'h0000_0044);
   endtask

   task automatic test_malformed();
      send_request(req_word(8'h55, OP_GET, 16'h0030, 32'h0000_0051), 64'h0, 1, 1'b1);
      send_request(req_word(REQ_MAGIC, 8'h07, 16'h0030, 32'h0000_0052), 64'h0, 1, 1'b1);
      send_request(req_word(REQ_MAGIC, OP_SET, 16'h0030, 32'h0000_0053), 64'h0, 1, 1'b1);
      send_request(req_word(REQ_MAGIC, OP_GET, 16'h0030, 32'h0000_0054), 64'h1, 2, 1'b1);
      expect_silence(20);
      do_request(OP_GET, 16'h0030, 64'h0, 32'h0000_0055);
   endtask

   task automatic test_random_burst();
      logic [63:0] hdr_w [BURST_LEN];
      logic [63:0] val_w [BURST_LEN];
      int          len_w [BURST_LEN];
      kv_resp_t    exp_r [BURST_LEN];
      kv_op_e      op;
      logic [31:0] rnd;
      logic [15:0] key;
      logic [31:0] opaque;
      for (int i = 0; i < BURST_LEN; i++) begin
         rnd = $random(seed);
         case (rnd % 3)
            0:       op = OP_GET;
            1:       op = OP_SET;
            default: op = OP_DELETE;
         endcase
         rnd = $random(seed);
         // small key space so hits and collisions happen
         key = rnd[15:0] & 16'h1103;
         val_w[i] = {$random(seed), $random(seed)};
         opaque = $random(seed);
         predict(op, key, val_w[i], opaque, exp_r[i]);
         hdr_w[i] = req_word(REQ_MAGIC, op, key, opaque);
         len_w[i] = (op == OP_SET) ? 2 : 1;
      end
      fork
         begin
            for (int i = 0; i < BURST_LEN; i++) begin
               send_request(hdr_w[i], val_w[i], len_w[i], i == BURST_LEN - 1);
            end
         end
         begin
            for (int j = 0; j < BURST_LEN; j++) begin
               expect_response(exp_r[j], 1'b1);
            end
         end
      join
   endtask

   initial begin
      arst_n    = 1'b1;
      in_valid  = 1'b0;
      in_beat   = '0;
      out_ready = 1'b0;
      @(negedge axi_clk);
      arst_n = 1'b0;
      repeat (5) @(negedge axi_clk);
      arst_n = 1'b1;
      test_get_empty();
      test_set_get();
      test_delete();
      test_collision();
      test_malformed();
      test_random_burst();
      if (dut.props.fail_count == 0) begin
         $display("Test passed");
         $finish;
      end else begin
         stop_on_error("a stream assertion in the bound checker failed");
      end
   end

endmodule

//--- vlog.f
hw/kv_pkg.sv
hw/request_parser.sv
hw/kv_control.sv
hw/hash_table.sv
hw/response_composer.sv
hw/kv_top.sv
verification/kv_props.sv
verification/tb_kv_top.sv
